// File: bench/exu_tb_table.svh
// columns: name, uop0, uop1, cycles, random operands (1) or fixed a and b (0),
//   ex1_readygo and wb_allowin patterns (bit n drives cycle n mod 8), flush cycle or -1,
//   a, b, upstream exception code (bit 6 raises the flag), upstream bad address
task automatic build_table();
    add_test("alu_add_sub", UOP_ADD, UOP_SUB, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("alu_sub_and", UOP_SUB, UOP_AND, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("alu_and_or", UOP_AND, UOP_OR, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("alu_or_xor", UOP_OR, UOP_XOR, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("alu_xor_sll", UOP_XOR, UOP_SLL, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("alu_sll_srl", UOP_SLL, UOP_SRL, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("alu_srl_sra", UOP_SRL, UOP_SRA, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("alu_sra_slt", UOP_SRA, UOP_SLT, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("alu_slt_sltu", UOP_SLT, UOP_SLTU, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("alu_sltu_add", UOP_SLTU, UOP_ADD, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("mul_w_rand", UOP_MUL_W, UOP_ADD, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("mulh_w_rand", UOP_MULH_W, UOP_SUB, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("mulh_wu_rand", UOP_MULH_WU, UOP_XOR, 8, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("mul_w_min_neg1", UOP_MUL_W, UOP_ADD, 1, 1'b0,
             8'hff, 8'hff, -1, 32'h8000_0000, 32'hffff_ffff, 7'h00, 32'h0);
    add_test("mulh_w_min_min", UOP_MULH_W, UOP_ADD, 1, 1'b0,
             8'hff, 8'hff, -1, 32'h8000_0000, 32'h8000_0000, 7'h00, 32'h0);
    add_test("mulh_w_min_max", UOP_MULH_W, UOP_ADD, 1, 1'b0,
             8'hff, 8'hff, -1, 32'h8000_0000, 32'h7fff_ffff, 7'h00, 32'h0);
    add_test("mulh_w_neg_pos", UOP_MULH_W, UOP_ADD, 1, 1'b0,
             8'hff, 8'hff, -1, 32'hffff_fff9, 32'h0001_2345, 7'h00, 32'h0);
    add_test("mulh_wu_max_min", UOP_MULH_WU, UOP_ADD, 1, 1'b0,
             8'hff, 8'hff, -1, 32'hffff_ffff, 32'h8000_0000, 7'h00, 32'h0);
    add_test("ld_aligned", UOP_LD_W, UOP_ADD, 1, 1'b0,
             8'hff, 8'hff, -1, 32'h0000_1000, 32'h0000_0004, 7'h00, 32'h0);
    add_test("ld_misaligned", UOP_LD_W, UOP_ADD, 3, 1'b0,
             8'hff, 8'hff, -1, 32'h0000_1000, 32'h0000_0002, 7'h00, 32'h0);
    add_test("ld_upstream_excp", UOP_LD_W, UOP_ADD, 1, 1'b0,
             8'hff, 8'hff, -1, 32'h0000_1000, 32'h0000_0001, 7'h4d, 32'h0bad_0010);
    add_test("backpressure", UOP_ADD, UOP_XOR, 10, 1'b1,
             8'hff, 8'b1100_0011, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("bubbles", UOP_SUB, UOP_AND, 8, 1'b1,
             8'b0101_0101, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("no_readygo", UOP_OR, UOP_SLT, 4, 1'b1,
             8'h00, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("flush_mid", UOP_ADD, UOP_SRA, 6, 1'b1,
             8'hff, 8'hff, 3, 32'h0, 32'h0, 7'h00, 32'h0);
    add_test("after_flush", UOP_MULH_W, UOP_SLTU, 4, 1'b1,
             8'hff, 8'hff, -1, 32'h0, 32'h0, 7'h00, 32'h0);
endtask

// File: bench/exu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exu_tb;
    import exu_pkg::*;

    localparam int DRAIN_LIMIT = 8;

    // one table row is one test
    typedef struct {
        string      name;
        uop_t       uop0;
        uop_t       uop1;
        int         cycles;
        bit         rnd;
        logic [7:0] rgo_pat;
        logic [7:0] allow_pat;
        int         flush_at;
        word_t      a;
        word_t      b;
        excp_code_t code;
        word_t      badv;
    } test_row_t;

    // expected wb contents of one item
    typedef struct packed {
        logic       present;
        logic       valid0;
        logic       valid1;
        logic       excp;
        word_t      pc0;
        word_t      pc1;
        reg_idx_t   rd0;
        reg_idx_t   rd1;
        word_t      data0;
        word_t      data1;
        excp_code_t code;
        word_t      badv;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        valid0, valid1;
    word_t       pc0, pc1;
    uop_t        uop0, uop1;
    reg_idx_t    rd0, rd1;
    word_t       src_a0, src_b0, src_a1, src_b1;
    logic        ex1_readygo, flush, wb_allowin, excp_flag_in;
    excp_code_t  exception_in;
    word_t       badv_in;

    logic        ex1_allowin;
    logic        wb_valid0, wb_valid1, wb_excp_flag;
    word_t       wb_pc0, wb_pc1, wb_data0, wb_data1, wb_badv;
    reg_idx_t    wb_rd0, wb_rd1;
    excp_code_t  wb_exception;

    test_row_t   tests[$];
    // model of the ex2 and wb registers
    exp_t        slot_ex2;
    exp_t        slot_wb;
    logic [31:0] lfsr;
    bit          accepted;
    bit          timed_out;
    int          item_no;
    int          checks;
    int          test_errs;
    int          total_errs;
    int          written;
    string       cur_name;

    exu_top dut0 (.*);

    always #50 clk = ~clk;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    task automatic draw_word(output word_t w);
        int k;
        w = '0;
        for (k = 0; k < 32; k++) begin
            w = {w[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic word_t alu_expect(input uop_t op, input word_t a, input word_t b);
        logic [63:0] ext;
        ext = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            UOP_ADD, UOP_LD_W: return a + b;
            UOP_SUB:  return a + ~b + 32'd1;
            UOP_AND:  return a & b;
            UOP_OR:   return a | b;
            UOP_XOR:  return a ^ b;
            UOP_SLL:  return a << b[4:0];
            UOP_SRL:  return a >> b[4:0];
            UOP_SRA:  return ext[31:0];
            // flipping the sign bits turns a signed compare into an unsigned one
            UOP_SLT:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            UOP_SLTU: return {31'b0, a < b};
            default:  return 32'h0;
        endcase
    endfunction

    function automatic word_t lane0_expect(input uop_t op, input word_t a, input word_t b);
        logic signed [63:0] sprod;
        logic [63:0]        uprod;
        sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        uprod = {32'h0, a} * {32'h0, b};
        case (op)
            UOP_MUL_W:   return uprod[31:0];
            UOP_MULH_W:  return sprod[63:32];
            UOP_MULH_WU: return uprod[63:32];
            default:     return alu_expect(op, a, b);
        endcase
    endfunction

    // what the wb outputs should show for the item now on the inputs
    function automatic exp_t expected_item();
        exp_t  e;
        word_t addr;
        logic  mis;
        e = '0;
        addr = src_a0 + src_b0;
        mis = valid0 && (uop0 == UOP_LD_W) && (addr[1:0] != 2'b00);
        e.excp = excp_flag_in | mis;
        e.code = excp_flag_in ? exception_in : (mis ? EXCP_ALE : 7'h00);
        e.badv = excp_flag_in ? badv_in : (mis ? addr : 32'h0);
        e.valid0 = valid0 & ~e.excp;
        e.valid1 = valid1 & ~e.excp;
        e.pc0 = pc0;
        e.pc1 = pc1;
        e.rd0 = rd0;
        e.rd1 = rd1;
        e.data0 = e.excp ? 32'h0 : lane0_expect(uop0, src_a0, src_b0);
        e.data1 = e.excp ? 32'h0 : alu_expect(uop1, src_a1, src_b1);
        e.present = valid0 | valid1 | e.excp;
        return e;
    endfunction

    task automatic add_test(input string name, input uop_t u0, input uop_t u1,
                            input int cycles, input bit rnd, input logic [7:0] rgo_pat,
                            input logic [7:0] allow_pat, input int flush_at,
                            input word_t a, input word_t b, input excp_code_t code,
                            input word_t badv);
        test_row_t t;
        t.name = name;
        t.uop0 = u0;
        t.uop1 = u1;
        t.cycles = cycles;
        t.rnd = rnd;
        t.rgo_pat = rgo_pat;
        t.allow_pat = allow_pat;
        t.flush_at = flush_at;
        t.a = a;
        t.b = b;
        t.code = code;
        t.badv = badv;
        tests.push_back(t);
    endtask

    `include "exu_tb_table.svh"

    task automatic idle_inputs();
        valid0 = 1'b0;
        valid1 = 1'b0;
        uop0 = UOP_NOP;
        uop1 = UOP_NOP;
        ex1_readygo = 1'b1;
        wb_allowin = 1'b1;
        flush = 1'b0;
        excp_flag_in = 1'b0;
        exception_in = 7'h00;
        badv_in = 32'h0;
    endtask

    // a new item only when the last one was taken, otherwise upstream holds it
    task automatic present_inputs(input test_row_t t, input int cyc);
        if (accepted) begin
            item_no++;
            if (t.rnd) begin
                draw_word(src_a0);
                draw_word(src_b0);
                draw_word(src_a1);
                draw_word(src_b1);
            end else begin
                src_a0 = t.a;
                src_b0 = t.b;
                src_a1 = t.b;
                src_b1 = t.a;
            end
            pc0 = 32'h1c00_0000 + (item_no << 3);
            pc1 = pc0 + 32'd4;
            rd0 = item_no[4:0];
            rd1 = ~item_no[4:0];
        end
        valid0 = 1'b1;
        valid1 = 1'b1;
        uop0 = t.uop0;
        uop1 = t.uop1;
        ex1_readygo = t.rgo_pat[cyc[2:0]];
        wb_allowin = t.allow_pat[cyc[2:0]];
        flush = (cyc == t.flush_at);
        excp_flag_in = t.code[6];
        exception_in = t.code;
        badv_in = t.badv;
    endtask

    // inputs were set at the falling edge, so they are stable here
    task automatic advance_model();
        if (flush) begin
            slot_ex2 = '0;
            slot_wb = '0;
            accepted = 1'b1;
        end else if (wb_allowin) begin
            slot_wb = slot_ex2;
            if (slot_ex2.present)
                written++;
            slot_ex2 = ex1_readygo ? expected_item() : '0;
            accepted = ex1_readygo;
        end else begin
            accepted = 1'b0;
        end
    endtask

    task automatic check_field(input string field, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            $display("Error %s %s: expected %h, actual %h", cur_name, field, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_outputs();
        check_field("ex1_allowin", 32'(wb_allowin), 32'(ex1_allowin));
        check_field("wb_valid0", 32'(slot_wb.valid0), 32'(wb_valid0));
        check_field("wb_valid1", 32'(slot_wb.valid1), 32'(wb_valid1));
        check_field("wb_excp_flag", 32'(slot_wb.excp), 32'(wb_excp_flag));
        // payload is only defined while an item sits in wb
        if (slot_wb.present) begin
            check_field("wb_pc0", slot_wb.pc0, wb_pc0);
            check_field("wb_pc1", slot_wb.pc1, wb_pc1);
            check_field("wb_rd0", 32'(slot_wb.rd0), 32'(wb_rd0));
            check_field("wb_rd1", 32'(slot_wb.rd1), 32'(wb_rd1));
            check_field("wb_data0", slot_wb.data0, wb_data0);
            check_field("wb_data1", slot_wb.data1, wb_data1);
            check_field("wb_exception", 32'(slot_wb.code), 32'(wb_exception));
            check_field("wb_badv", slot_wb.badv, wb_badv);
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        advance_model();
        @(negedge clk);
        check_outputs();
    endtask

    function automatic bit pipe_busy();
        return slot_ex2.present || slot_wb.present || wb_valid0 || wb_valid1 || wb_excp_flag;
    endfunction

    task automatic run_test(input test_row_t t);
        int cyc;
        int waited;
        cur_name = t.name;
        test_errs = 0;
        written = 0;
        accepted = 1'b1;
        for (cyc = 0; cyc < t.cycles; cyc++) begin
            present_inputs(t, cyc);
            run_cycle();
        end
        // empty the pipe before the next test
        idle_inputs();
        waited = 0;
        while (pipe_busy() && waited < DRAIN_LIMIT) begin
            run_cycle();
            waited++;
        end
        if (pipe_busy()) begin
            $display("Timeout in %s: pipeline still busy after %0d idle cycles",
                     t.name, DRAIN_LIMIT);
            test_errs++;
            timed_out = 1'b1;
        end
        total_errs += test_errs;
        $display("%s: %0d items written back, %0d errors", t.name, written, test_errs);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        pc0 = 32'h0;
        pc1 = 32'h0;
        rd0 = 5'd0;
        rd1 = 5'd0;
        src_a0 = 32'h0;
        src_b0 = 32'h0;
        src_a1 = 32'h0;
        src_b1 = 32'h0;
        idle_inputs();
        slot_ex2 = '0;
        slot_wb = '0;
        lfsr = 32'h527;
        accepted = 1'b1;
        timed_out = 1'b0;
        item_no = 0;
        checks = 0;
        total_errs = 0;
        build_table();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        foreach (tests[n]) begin
            if (!timed_out)
                run_test(tests[n]);
        end

        $display("%0d tests, %0d checks, %0d errors", tests.size(), checks, total_errs);
        if (total_errs == 0 && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/ex1_alu_mul.sv
`timescale 1ns/100ps
`default_nettype none

module ex1_alu_mul (
    input  wire exu_pkg::uop_t       uop0,
    input  wire exu_pkg::uop_t       uop1,
    input  wire exu_pkg::word_t      src_a0,
    input  wire exu_pkg::word_t      src_b0,
    input  wire exu_pkg::word_t      src_a1,
    input  wire exu_pkg::word_t      src_b1,
    input  wire                      valid0,
    input  wire                      valid1,

    output exu_pkg::word_t           alu_result0,
    output exu_pkg::word_t           alu_result1,
    output logic                     alu_result0_valid,
    output logic                     alu_result1_valid,
    output exu_pkg::half_prod_t      mul_res_hh,
    output exu_pkg::half_prod_t      mul_res_hl,
    output exu_pkg::half_prod_t      mul_res_lh,
    output exu_pkg::half_prod_t      mul_res_ll,
    output exu_pkg::word_t           mul_compensate,
    output exu_pkg::excp_code_t      d_exception,
    output exu_pkg::word_t           d_badv
);
    import exu_pkg::*;

    logic  is_mul0;
    logic  is_mul1;
    logic  signed_mul;
    logic  misaligned;
    word_t mul_a;
    word_t mul_b;
    word_t corr_a;
    word_t corr_b;

    // single-cycle integer ops, ld_w reuses the adder for its address
    function automatic word_t alu_calc(uop_t op, word_t a, word_t b);
        word_t r;
        case (op)
            UOP_ADD, UOP_LD_W: r = a + b;
            UOP_SUB:  r = a - b;
            UOP_AND:  r = a & b;
            UOP_OR:   r = a | b;
            UOP_XOR:  r = a ^ b;
            UOP_SLL:  r = a << b[4:0];
            UOP_SRL:  r = a >> b[4:0];
            UOP_SRA:  r = word_t'($signed(a) >>> b[4:0]);
            UOP_SLT:  r = {{(WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
            UOP_SLTU: r = {{(WORD_W-1){1'b0}}, a < b};
            default:  r = '0;
        endcase
        return r;
    endfunction

    assign is_mul0 = is_mul_uop(uop0);
    assign is_mul1 = is_mul_uop(uop1);

    assign alu_result0 = alu_calc(uop0, src_a0, src_b0);
    assign alu_result1 = alu_calc(uop1, src_a1, src_b1);

    // multiplies finish in ex2, so no result valid here
    assign alu_result0_valid = valid0 & ~is_mul0;
    assign alu_result1_valid = valid1 & ~is_mul1;

    // keep the multiplier quiet for non-multiply ops
    assign mul_a = is_mul0 ? src_a0 : '0;
    assign mul_b = is_mul0 ? src_b0 : '0;

    // unsigned 16x16 partial products
    assign mul_res_hh = mul_a[WORD_W-1:HALF_W] * mul_b[WORD_W-1:HALF_W];
    assign mul_res_hl = mul_a[WORD_W-1:HALF_W] * mul_b[HALF_W-1:0];
    assign mul_res_lh = mul_a[HALF_W-1:0] * mul_b[WORD_W-1:HALF_W];
    assign mul_res_ll = mul_a[HALF_W-1:0] * mul_b[HALF_W-1:0];

    // signed high word: subtract b when a < 0 and a when b < 0
    assign signed_mul = (uop0 == UOP_MULH_W);
    assign corr_a = mul_a[WORD_W-1] ? mul_b : '0;
    assign corr_b = mul_b[WORD_W-1] ? mul_a : '0;
    assign mul_compensate = signed_mul ? -(corr_a + corr_b) : '0;

    // word loads need the low two address bits clear
    assign misaligned = valid0 & (uop0 == UOP_LD_W) & (|alu_result0[1:0]);
    assign d_exception = misaligned ? EXCP_ALE : EXCP_NONE;
    assign d_badv = misaligned ? alu_result0 : '0;

    // lane 1 has no multiplier
    always_comb begin
        if (valid1) begin
            assert (!is_mul1)
                else $error("multiply op issued to lane 1: %s", uop1.name());
        end
    end

endmodule

`default_nettype wire

// File: hw/ex1_ex2_reg.sv
`timescale 1ns/100ps
`default_nettype none

module ex1_ex2_reg (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      flush,
    input  wire                      ex1_readygo,
    input  wire                      ex2_allowin,

    input  wire exu_pkg::word_t      pc0,
    input  wire exu_pkg::word_t      pc1,
    input  wire exu_pkg::reg_idx_t   rd0,
    input  wire exu_pkg::reg_idx_t   rd1,
    input  wire exu_pkg::uop_t       uop0,
    input  wire exu_pkg::uop_t       uop1,
    input  wire                      valid0,
    input  wire                      valid1,
    input  wire exu_pkg::word_t      alu_result0,
    input  wire exu_pkg::word_t      alu_result1,
    input  wire                      alu_result0_valid,
    input  wire                      alu_result1_valid,
    input  wire exu_pkg::half_prod_t mul_res_hh,
    input  wire exu_pkg::half_prod_t mul_res_hl,
    input  wire exu_pkg::half_prod_t mul_res_lh,
    input  wire exu_pkg::half_prod_t mul_res_ll,
    input  wire exu_pkg::word_t      mul_compensate,
    input  wire exu_pkg::excp_code_t d_exception,
    input  wire exu_pkg::word_t      d_badv,
    input  wire                      excp_flag_in,
    input  wire exu_pkg::excp_code_t exception_in,
    input  wire exu_pkg::word_t      badv_in,

    output exu_pkg::word_t           ex1_ex2_pc0,
    output exu_pkg::word_t           ex1_ex2_pc1,
    output exu_pkg::reg_idx_t        ex1_ex2_rd0,
    output exu_pkg::reg_idx_t        ex1_ex2_rd1,
    output exu_pkg::uop_t            ex1_ex2_uop0,
    output exu_pkg::uop_t            ex1_ex2_uop1,
    output logic                     ex1_ex2_valid0,
    output logic                     ex1_ex2_valid1,
    output exu_pkg::word_t           ex1_ex2_alu_result0,
    output exu_pkg::word_t           ex1_ex2_alu_result1,
    output logic                     ex1_ex2_alu_result0_valid,
    output logic                     ex1_ex2_alu_result1_valid,
    output exu_pkg::half_prod_t      ex1_ex2_mul_res_hh,
    output exu_pkg::half_prod_t      ex1_ex2_mul_res_hl,
    output exu_pkg::half_prod_t      ex1_ex2_mul_res_lh,
    output exu_pkg::half_prod_t      ex1_ex2_mul_res_ll,
    output exu_pkg::word_t           ex1_ex2_mul_compensate,
    output logic                     ex1_ex2_excp_flag,
    output exu_pkg::excp_code_t      ex1_ex2_exception,
    output exu_pkg::word_t           ex1_ex2_badv
);
    import exu_pkg::*;

    logic capture;
    logic bubble;
    logic merged_flag;

    assign capture = ex1_readygo & ex2_allowin;
    assign bubble  = ~ex1_readygo & ex2_allowin;

    // upstream exception wins over the local one
    assign merged_flag = excp_flag_in | d_exception[EXCP_VALID_BIT];

    // control fields: cleared by flush and bubble as well as reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex1_ex2_uop0 <= INST_NOP_UOP;
            ex1_ex2_uop1 <= INST_NOP_UOP;
            ex1_ex2_valid0 <= 1'b0;
            ex1_ex2_valid1 <= 1'b0;
            ex1_ex2_alu_result0_valid <= 1'b0;
            ex1_ex2_alu_result1_valid <= 1'b0;
            ex1_ex2_excp_flag <= 1'b0;
        end else if (flush || bubble) begin
            ex1_ex2_uop0 <= INST_NOP_UOP;
            ex1_ex2_uop1 <= INST_NOP_UOP;
            ex1_ex2_valid0 <= 1'b0;
            ex1_ex2_valid1 <= 1'b0;
            ex1_ex2_alu_result0_valid <= 1'b0;
            ex1_ex2_alu_result1_valid <= 1'b0;
            ex1_ex2_excp_flag <= 1'b0;
        end else if (capture) begin
            ex1_ex2_uop0 <= uop0;
            ex1_ex2_uop1 <= uop1;
            // excepting items keep their valids, ex2 suppresses writeback
            ex1_ex2_valid0 <= valid0;
            ex1_ex2_valid1 <= valid1;
            ex1_ex2_alu_result0_valid <= alu_result0_valid;
            ex1_ex2_alu_result1_valid <= alu_result1_valid;
            ex1_ex2_excp_flag <= merged_flag;
        end
    end

    // payload follows the item, only meaningful while its valid is set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex1_ex2_pc0 <= '0;
            ex1_ex2_pc1 <= '0;
            ex1_ex2_rd0 <= '0;
            ex1_ex2_rd1 <= '0;
            ex1_ex2_alu_result0 <= '0;
            ex1_ex2_alu_result1 <= '0;
            ex1_ex2_mul_res_hh <= '0;
            ex1_ex2_mul_res_hl <= '0;
            ex1_ex2_mul_res_lh <= '0;
            ex1_ex2_mul_res_ll <= '0;
            ex1_ex2_mul_compensate <= '0;
            ex1_ex2_exception <= '0;
            ex1_ex2_badv <= '0;
        end else if (capture) begin
            ex1_ex2_pc0 <= pc0;
            ex1_ex2_pc1 <= pc1;
            ex1_ex2_rd0 <= rd0;
            ex1_ex2_rd1 <= rd1;
            ex1_ex2_alu_result0 <= alu_result0;
            ex1_ex2_alu_result1 <= alu_result1;
            ex1_ex2_mul_res_hh <= mul_res_hh;
            ex1_ex2_mul_res_hl <= mul_res_hl;
            ex1_ex2_mul_res_lh <= mul_res_lh;
            ex1_ex2_mul_res_ll <= mul_res_ll;
            ex1_ex2_mul_compensate <= mul_compensate;
            ex1_ex2_exception <= excp_flag_in ? exception_in : d_exception;
            ex1_ex2_badv <= excp_flag_in ? badv_in : d_badv;
        end
    end

    // an exception always belongs to a real lane 0 op
    a_flag_has_lane0 : assert property (@(posedge clk) disable iff (!rst_n)
        ex1_ex2_excp_flag |-> ex1_ex2_valid0)
        else $error("exception flag stored without a valid lane 0 op");

endmodule

`default_nettype wire

// File: hw/ex2_mul_merge.sv
`timescale 1ns/100ps
`default_nettype none

module ex2_mul_merge (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      flush,
    input  wire                      wb_allowin,

    input  wire exu_pkg::word_t      ex1_ex2_pc0,
    input  wire exu_pkg::word_t      ex1_ex2_pc1,
    input  wire exu_pkg::reg_idx_t   ex1_ex2_rd0,
    input  wire exu_pkg::reg_idx_t   ex1_ex2_rd1,
    input  wire exu_pkg::uop_t       ex1_ex2_uop0,
    input  wire exu_pkg::uop_t       ex1_ex2_uop1,
    input  wire                      ex1_ex2_valid0,
    input  wire                      ex1_ex2_valid1,
    input  wire exu_pkg::word_t      ex1_ex2_alu_result0,
    input  wire exu_pkg::word_t      ex1_ex2_alu_result1,
    input  wire                      ex1_ex2_alu_result0_valid,
    input  wire                      ex1_ex2_alu_result1_valid,
    input  wire exu_pkg::half_prod_t ex1_ex2_mul_res_hh,
    input  wire exu_pkg::half_prod_t ex1_ex2_mul_res_hl,
    input  wire exu_pkg::half_prod_t ex1_ex2_mul_res_lh,
    input  wire exu_pkg::half_prod_t ex1_ex2_mul_res_ll,
    input  wire exu_pkg::word_t      ex1_ex2_mul_compensate,
    input  wire                      ex1_ex2_excp_flag,
    input  wire exu_pkg::excp_code_t ex1_ex2_exception,
    input  wire exu_pkg::word_t      ex1_ex2_badv,

    output logic                     wb_valid0,
    output logic                     wb_valid1,
    output exu_pkg::word_t           wb_pc0,
    output exu_pkg::word_t           wb_pc1,
    output exu_pkg::reg_idx_t        wb_rd0,
    output exu_pkg::reg_idx_t        wb_rd1,
    output exu_pkg::word_t           wb_data0,
    output exu_pkg::word_t           wb_data1,
    output logic                     wb_excp_flag,
    output exu_pkg::excp_code_t      wb_exception,
    output exu_pkg::word_t           wb_badv
);
    import exu_pkg::*;

    logic [2*WORD_W-1:0] prod_base;
    logic [2*WORD_W-1:0] cross_sum;
    logic [2*WORD_W-1:0] product;
    word_t               mul_hi;
    word_t               mul_lo;
    word_t               result0;

    // hh and ll do not overlap, so they just concatenate
    assign prod_base = {ex1_ex2_mul_res_hh, ex1_ex2_mul_res_ll};
    assign cross_sum = {{WORD_W{1'b0}}, ex1_ex2_mul_res_hl}
                     + {{WORD_W{1'b0}}, ex1_ex2_mul_res_lh};
    assign product = prod_base + (cross_sum << HALF_W);

    // correction is zero except for mulh_w
    assign mul_hi = product[2*WORD_W-1:WORD_W] + ex1_ex2_mul_compensate;
    assign mul_lo = product[WORD_W-1:0];

    always_comb begin
        case (ex1_ex2_uop0)
            UOP_MUL_W:               result0 = mul_lo;
            UOP_MULH_W, UOP_MULH_WU: result0 = mul_hi;
            default:                 result0 = ex1_ex2_alu_result0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid0 <= 1'b0;
            wb_valid1 <= 1'b0;
            wb_pc0 <= '0;
            wb_pc1 <= '0;
            wb_rd0 <= '0;
            wb_rd1 <= '0;
            wb_data0 <= '0;
            wb_data1 <= '0;
            wb_excp_flag <= 1'b0;
            wb_exception <= '0;
            wb_badv <= '0;
        end else if (flush) begin
            wb_valid0 <= 1'b0;
            wb_valid1 <= 1'b0;
            wb_pc0 <= '0;
            wb_pc1 <= '0;
            wb_rd0 <= '0;
            wb_rd1 <= '0;
            wb_data0 <= '0;
            wb_data1 <= '0;
            wb_excp_flag <= 1'b0;
            wb_exception <= '0;
            wb_badv <= '0;
        end else if (wb_allowin) begin
            // an excepting pair writes nothing back
            wb_valid0 <= ex1_ex2_valid0 & ~ex1_ex2_excp_flag;
            wb_valid1 <= ex1_ex2_valid1 & ~ex1_ex2_excp_flag;
            wb_pc0 <= ex1_ex2_pc0;
            wb_pc1 <= ex1_ex2_pc1;
            wb_rd0 <= ex1_ex2_rd0;
            wb_rd1 <= ex1_ex2_rd1;
            wb_data0 <= ex1_ex2_excp_flag ? '0 : result0;
            wb_data1 <= ex1_ex2_excp_flag ? '0 : ex1_ex2_alu_result1;
            wb_excp_flag <= ex1_ex2_excp_flag;
            wb_exception <= ex1_ex2_exception;
            wb_badv <= ex1_ex2_badv;
        end
    end

    // lane 1 is always finished in ex1
    a_lane1_done : assert property (@(posedge clk) disable iff (!rst_n)
        ex1_ex2_valid1 |-> ex1_ex2_alu_result1_valid)
        else $error("lane 1 valid without an ex1 result, uop %s", ex1_ex2_uop1.name());

endmodule

`default_nettype wire

// File: hw/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // datapath widths
    localparam int WORD_W = 32;
    localparam int HALF_W = WORD_W / 2;
    localparam int REG_IDX_W = 5;
    localparam int EXCP_CODE_W = 7;
    localparam int UOP_W = 4;

    // top bit of an exception code marks it as valid
    localparam int EXCP_VALID_BIT = 6;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [EXCP_CODE_W-1:0] excp_code_t;
    typedef logic [2*HALF_W-1:0] half_prod_t;

    typedef enum logic [UOP_W-1:0] {
        UOP_NOP     = 4'd0,
        UOP_ADD     = 4'd1,
        UOP_SUB     = 4'd2,
        UOP_AND     = 4'd3,
        UOP_OR      = 4'd4,
        UOP_XOR     = 4'd5,
        UOP_SLL     = 4'd6,
        UOP_SRL     = 4'd7,
        UOP_SRA     = 4'd8,
        UOP_SLT     = 4'd9,
        UOP_SLTU    = 4'd10,
        UOP_MUL_W   = 4'd11,
        UOP_MULH_W  = 4'd12,
        UOP_MULH_WU = 4'd13,
        UOP_LD_W    = 4'd14
    } uop_t;

    localparam excp_code_t EXCP_NONE = '0;
    // address misaligned: valid bit plus code 0x09
    localparam excp_code_t EXCP_ALE = 7'h49;

    // op loaded for a bubble
    localparam uop_t INST_NOP_UOP = UOP_NOP;

    // ops whose result is finished in ex2
    function automatic logic is_mul_uop(uop_t op);
        return (op == UOP_MUL_W) || (op == UOP_MULH_W) || (op == UOP_MULH_WU);
    endfunction

endpackage

`default_nettype wire

// File: hw/exu_top.sv
`timescale 1ns/100ps
`default_nettype none

module exu_top (
    input  wire                      clk,
    input  wire                      rst_n,

    // issue lanes
    input  wire                      valid0,
    input  wire exu_pkg::word_t      pc0,
    input  wire exu_pkg::uop_t       uop0,
    input  wire exu_pkg::reg_idx_t   rd0,
    input  wire exu_pkg::word_t      src_a0,
    input  wire exu_pkg::word_t      src_b0,
    input  wire                      valid1,
    input  wire exu_pkg::word_t      pc1,
    input  wire exu_pkg::uop_t       uop1,
    input  wire exu_pkg::reg_idx_t   rd1,
    input  wire exu_pkg::word_t      src_a1,
    input  wire exu_pkg::word_t      src_b1,

    input  wire                      ex1_readygo,
    input  wire                      flush,
    input  wire                      wb_allowin,
    input  wire                      excp_flag_in,
    input  wire exu_pkg::excp_code_t exception_in,
    input  wire exu_pkg::word_t      badv_in,

    output wire                      ex1_allowin,
    output wire                      wb_valid0,
    output wire                      wb_valid1,
    output wire exu_pkg::word_t      wb_pc0,
    output wire exu_pkg::word_t      wb_pc1,
    output wire exu_pkg::reg_idx_t   wb_rd0,
    output wire exu_pkg::reg_idx_t   wb_rd1,
    output wire exu_pkg::word_t      wb_data0,
    output wire exu_pkg::word_t      wb_data1,
    output wire                      wb_excp_flag,
    output wire exu_pkg::excp_code_t wb_exception,
    output wire exu_pkg::word_t      wb_badv
);
    import exu_pkg::*;

    logic       ex2_allowin;

    // ex1 results
    word_t      alu_result0;
    word_t      alu_result1;
    logic       alu_result0_valid;
    logic       alu_result1_valid;
    half_prod_t mul_res_hh;
    half_prod_t mul_res_hl;
    half_prod_t mul_res_lh;
    half_prod_t mul_res_ll;
    word_t      mul_compensate;
    excp_code_t d_exception;
    word_t      d_badv;

    // ex1/ex2 register contents
    word_t      ex1_ex2_pc0;
    word_t      ex1_ex2_pc1;
    reg_idx_t   ex1_ex2_rd0;
    reg_idx_t   ex1_ex2_rd1;
    uop_t       ex1_ex2_uop0;
    uop_t       ex1_ex2_uop1;
    logic       ex1_ex2_valid0;
    logic       ex1_ex2_valid1;
    word_t      ex1_ex2_alu_result0;
    word_t      ex1_ex2_alu_result1;
    logic       ex1_ex2_alu_result0_valid;
    logic       ex1_ex2_alu_result1_valid;
    half_prod_t ex1_ex2_mul_res_hh;
    half_prod_t ex1_ex2_mul_res_hl;
    half_prod_t ex1_ex2_mul_res_lh;
    half_prod_t ex1_ex2_mul_res_ll;
    word_t      ex1_ex2_mul_compensate;
    logic       ex1_ex2_excp_flag;
    excp_code_t ex1_ex2_exception;
    word_t      ex1_ex2_badv;

    // ex2 never stalls on its own, so the allowin chain is pure wiring of wb
    assign ex2_allowin = wb_allowin;
    assign ex1_allowin = ex2_allowin;

    ex1_alu_mul u_ex1 (.*);

    ex1_ex2_reg u_ex1_ex2 (.*);

    ex2_mul_merge u_ex2 (.*);

endmodule

`default_nettype wire

// File: project.f
+incdir+bench
hw/exu_pkg.sv
hw/ex1_alu_mul.sv
hw/ex1_ex2_reg.sv
hw/ex2_mul_merge.sv
hw/exu_top.sv
bench/exu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the exu testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -f "$LOG" "$BUILD_LOG"

verilator --binary --timing --assert -f project.f --top-module exu_tb \
    -Mdir obj_dir -o exu_sim > "$BUILD_LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/exu_sim > "$LOG" 2>&1
cat "$LOG"

grep -qF '*** TEST PASSED ***' "$LOG" && echo "simulation passed" \
    || { echo "simulation failed, see $LOG"; exit 1; }
